//--- src.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/inst_decoder.sv
src/alu.sv
src/exu.sv
src/result_buffer.sv
src/exu_subsystem.sv
verification/exu_assertions.sv
verification/exu_tb.sv

//--- src/alu.sv
`default_nettype none

module alu (
	input  isa_pkg::word_t  lhs,
	input  isa_pkg::word_t  rhs,
	input  isa_pkg::alu_op_t op,
	output isa_pkg::word_t  sum,
	output isa_pkg::word_t  res
);

	logic [32:0]    diff_ext;
	isa_pkg::word_t diff;
	logic           less;
	logic           uless;
	logic [4:0]     shamt;

	assign sum = lhs + rhs;  // also used for jump targets

	assign diff_ext = {1'b0, lhs} - {1'b0, rhs};
	assign diff     = diff_ext[31:0];
	assign uless    = diff_ext[32];  // borrow out

	// differing signs decide directly, otherwise the difference sign
	assign less = (lhs[31] & ~rhs[31]) | (~(lhs[31] ^ rhs[31]) & diff[31]);

	assign shamt = rhs[4:0];

	always_comb begin
		case (op)
			isa_pkg::ALU_ADD:
				res = sum;
			isa_pkg::ALU_SUB:
				res = diff;
			isa_pkg::ALU_AND:
				res = lhs & rhs;
			isa_pkg::ALU_XOR:
				res = lhs ^ rhs;
			isa_pkg::ALU_OR:
				res = lhs | rhs;
			isa_pkg::ALU_SRL:
				res = lhs >> shamt;
			isa_pkg::ALU_SRA:
				res = isa_pkg::word_t'($signed(lhs) >>> shamt);
			isa_pkg::ALU_SLL:
				res = lhs << shamt;
			isa_pkg::ALU_SLT:
				res = {31'b0, less};
			isa_pkg::ALU_SLTU:
				res = {31'b0, uless};
			default:
				res = sum;
		endcase
	end

endmodule

`default_nettype wire

//--- src/exu.sv
`default_nettype none

module exu (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  pipe_pkg::decoded_t    decoded,
	input  logic                  csr_redirect,
	input  isa_pkg::word_t        csr_target,
	output logic                  res_valid,
	input  logic                  res_ready,
	output pipe_pkg::exu_result_t result
);

	isa_pkg::op_class_t    cls;
	isa_pkg::word_t        lhs;
	isa_pkg::word_t        rhs;
	isa_pkg::alu_op_t      alu_op;
	isa_pkg::word_t        alu_sum;
	isa_pkg::word_t        alu_res;
	isa_pkg::word_t        snpc;
	isa_pkg::word_t        cmp_diff;
	logic                  cmp_borrow;
	logic                  cmp_less;
	logic                  branch_taken;
	logic                  jump_en;
	logic                  accept;
	pipe_pkg::exu_result_t res_next;

	assign cls    = decoded.op_class;
	assign accept = in_valid & in_ready;
	assign snpc   = decoded.pc + 32'd4;

	assign lhs = (cls[isa_pkg::CLS_AUIPC] | cls[isa_pkg::CLS_JAL] | cls[isa_pkg::CLS_BRANCH])
		? decoded.pc
		: (cls[isa_pkg::CLS_LUI] ? '0 : decoded.src1);
	assign rhs = cls[isa_pkg::CLS_OP] ? decoded.src2 : decoded.imm;

	always_comb begin
		alu_op = isa_pkg::ALU_ADD;  // addresses and targets
		if (cls[isa_pkg::CLS_OP] | cls[isa_pkg::CLS_OPIMM]) begin
			case (decoded.funct3)
				3'b000: alu_op = (cls[isa_pkg::CLS_OP] & decoded.funct7_5)
					? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
				3'b001: alu_op = isa_pkg::ALU_SLL;
				3'b010: alu_op = isa_pkg::ALU_SLT;
				3'b011: alu_op = isa_pkg::ALU_SLTU;
				3'b100: alu_op = isa_pkg::ALU_XOR;
				3'b101: alu_op = decoded.funct7_5 ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
				3'b110: alu_op = isa_pkg::ALU_OR;
				default: alu_op = isa_pkg::ALU_AND;
			endcase
		end
	end

	alu u_alu (
		.lhs(lhs),
		.rhs(rhs),
		.op (alu_op),
		.sum(alu_sum),
		.res(alu_res)
	);

	// branch compare on the register operands, alu is busy with the target
	assign {cmp_borrow, cmp_diff} = {1'b0, decoded.src1} - {1'b0, decoded.src2};
	assign cmp_less = (decoded.src1[31] & ~decoded.src2[31])
		| (~(decoded.src1[31] ^ decoded.src2[31]) & cmp_diff[31]);

	always_comb begin
		case (decoded.funct3)
			3'b000:  branch_taken = (cmp_diff == '0);  // beq
			3'b001:  branch_taken = (cmp_diff != '0);  // bne
			3'b100:  branch_taken = cmp_less;
			3'b101:  branch_taken = ~cmp_less;
			3'b110:  branch_taken = cmp_borrow;         // bltu
			3'b111:  branch_taken = ~cmp_borrow;
			default: branch_taken = 1'b0;
		endcase
	end

	assign jump_en = cls[isa_pkg::CLS_JAL] | cls[isa_pkg::CLS_JALR]
		| (cls[isa_pkg::CLS_BRANCH] & branch_taken);

	always_comb begin
		res_next.rd         = decoded.rd;
		res_next.pc         = decoded.pc;
		res_next.store_data = decoded.src2;
		res_next.funct3     = decoded.funct3;
		res_next.reg_wen    = decoded.reg_wen;
		res_next.load       = cls[isa_pkg::CLS_LOAD];
		res_next.store      = cls[isa_pkg::CLS_STORE];
		// trap or return wins over everything
		res_next.next_pc    = csr_redirect ? csr_target : (jump_en ? alu_sum : snpc);
		res_next.mispredict = (res_next.next_pc != decoded.dnpc);
		res_next.btb_update = res_next.mispredict
			& (cls[isa_pkg::CLS_JAL] | (cls[isa_pkg::CLS_BRANCH] & decoded.imm[31]));
		if (cls[isa_pkg::CLS_JAL] | cls[isa_pkg::CLS_JALR])
			res_next.val = snpc;  // link address
		else if (cls[isa_pkg::CLS_CSR])
			res_next.val = decoded.csr_val;
		else
			res_next.val = alu_res;
		res_next.csr_wen = cls[isa_pkg::CLS_CSR] & (decoded.funct3 != '0);
		case (decoded.funct3)
			3'b001:  res_next.csr_wdata = decoded.src1;  // csrrw
			3'b010:  res_next.csr_wdata = decoded.src1 | decoded.csr_val;
			default: res_next.csr_wdata = '0;
		endcase
		if (!cls[isa_pkg::CLS_CSR])
			res_next.csr_wdata = '0;
	end

	// two-flag handshake, never both high
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			in_ready  <= 1'b1;
			res_valid <= 1'b0;
		end else if (accept) begin
			in_ready  <= 1'b0;
			res_valid <= 1'b1;
		end else if (res_valid & res_ready) begin
			in_ready  <= 1'b1;
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			result <= res_next;
	end

endmodule

`default_nettype wire

//--- src/exu_subsystem.sv
`default_nettype none

module exu_subsystem (
	input  logic                  clock,
	input  logic                  rst_n,
	input  isa_pkg::word_t        inst,
	input  isa_pkg::word_t        pc,
	input  isa_pkg::word_t        dnpc,
	input  isa_pkg::word_t        src1,
	input  isa_pkg::word_t        src2,
	input  isa_pkg::word_t        csr_val,
	input  logic                  csr_redirect,
	input  isa_pkg::word_t        csr_target,
	input  logic                  in_valid,
	output logic                  in_ready,
	output logic                  out_valid,
	input  logic                  out_ready,
	output pipe_pkg::exu_result_t result
);

	pipe_pkg::decoded_t    decoded;
	pipe_pkg::exu_result_t exu_result;
	logic                  res_valid;
	logic                  res_ready;

	inst_decoder u_decoder (
		.inst   (inst),
		.pc     (pc),
		.dnpc   (dnpc),
		.src1   (src1),
		.src2   (src2),
		.csr_val(csr_val),
		.decoded(decoded)
	);

	exu u_exu (
		.clock       (clock),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.decoded     (decoded),
		.csr_redirect(csr_redirect),  // taken with the accepted instruction
		.csr_target  (csr_target),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.result      (exu_result)
	);

	result_buffer u_buffer (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (res_valid),
		.in_ready  (res_ready),
		.in_result (exu_result),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_result(result)
	);

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none

module inst_decoder (
	input  isa_pkg::word_t     inst,
	input  isa_pkg::word_t     pc,
	input  isa_pkg::word_t     dnpc,
	input  isa_pkg::word_t     src1,
	input  isa_pkg::word_t     src2,
	input  isa_pkg::word_t     csr_val,
	output pipe_pkg::decoded_t decoded
);

	isa_pkg::opcode_t   opcode;
	isa_pkg::op_class_t cls;
	isa_pkg::reg_idx_t  rd;
	isa_pkg::word_t     imm_i;
	isa_pkg::word_t     imm_s;
	isa_pkg::word_t     imm_b;
	isa_pkg::word_t     imm_u;
	isa_pkg::word_t     imm_j;
	isa_pkg::word_t     imm;
	logic               writes_rd;

	assign opcode = inst[6:0];
	assign rd     = inst[10:7];  // upper rd bit dropped in rv32e

	// immediates by format
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		cls = '0;  // unknown opcode decodes to no class
		case (opcode)
			isa_pkg::OPC_LUI:    cls[isa_pkg::CLS_LUI]    = 1'b1;
			isa_pkg::OPC_AUIPC:  cls[isa_pkg::CLS_AUIPC]  = 1'b1;
			isa_pkg::OPC_JAL:    cls[isa_pkg::CLS_JAL]    = 1'b1;
			isa_pkg::OPC_JALR:   cls[isa_pkg::CLS_JALR]   = 1'b1;
			isa_pkg::OPC_BRANCH: cls[isa_pkg::CLS_BRANCH] = 1'b1;
			isa_pkg::OPC_LOAD:   cls[isa_pkg::CLS_LOAD]   = 1'b1;
			isa_pkg::OPC_STORE:  cls[isa_pkg::CLS_STORE]  = 1'b1;
			isa_pkg::OPC_OPIMM:  cls[isa_pkg::CLS_OPIMM]  = 1'b1;
			isa_pkg::OPC_OP:     cls[isa_pkg::CLS_OP]     = 1'b1;
			isa_pkg::OPC_SYSTEM: cls[isa_pkg::CLS_CSR]    = 1'b1;
			default:             cls = '0;
		endcase
	end

	always_comb begin
		if (cls[isa_pkg::CLS_LUI] | cls[isa_pkg::CLS_AUIPC])
			imm = imm_u;
		else if (cls[isa_pkg::CLS_JAL])
			imm = imm_j;
		else if (cls[isa_pkg::CLS_BRANCH])
			imm = imm_b;
		else if (cls[isa_pkg::CLS_STORE])
			imm = imm_s;
		else
			imm = imm_i;  // jalr, loads, op-imm
	end

	// branch and store leave rd alone
	assign writes_rd = cls[isa_pkg::CLS_LUI] | cls[isa_pkg::CLS_AUIPC]
		| cls[isa_pkg::CLS_JAL] | cls[isa_pkg::CLS_JALR] | cls[isa_pkg::CLS_LOAD]
		| cls[isa_pkg::CLS_OPIMM] | cls[isa_pkg::CLS_OP] | cls[isa_pkg::CLS_CSR];

	always_comb begin
		decoded.op_class = cls;
		decoded.rd       = rd;
		decoded.funct3   = inst[14:12];
		decoded.funct7_5 = inst[30];
		decoded.imm      = imm;
		decoded.reg_wen  = writes_rd & (rd != '0);
		decoded.pc       = pc;
		decoded.dnpc     = dnpc;
		decoded.src1     = src1;
		decoded.src2     = src2;
		decoded.csr_val  = csr_val;
	end

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;   // rv32e, x0..x15
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [9:0]  op_class_t;  // one-hot, indexed by CLS_*
	typedef logic [3:0]  alu_op_t;

	// one-hot class bit positions
	localparam int CLS_LUI    = 0;
	localparam int CLS_AUIPC  = 1;
	localparam int CLS_JAL    = 2;
	localparam int CLS_JALR   = 3;
	localparam int CLS_BRANCH = 4;
	localparam int CLS_LOAD   = 5;
	localparam int CLS_STORE  = 6;
	localparam int CLS_OPIMM  = 7;
	localparam int CLS_OP     = 8;
	localparam int CLS_CSR    = 9;

	// major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OPIMM  = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_XOR  = 4'd3;
	localparam alu_op_t ALU_OR   = 4'd4;
	localparam alu_op_t ALU_SRL  = 4'd5;
	localparam alu_op_t ALU_SRA  = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SLT  = 4'd8;
	localparam alu_op_t ALU_SLTU = 4'd9;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// decoder output, consumed by the execute stage
	typedef struct packed {
		isa_pkg::op_class_t op_class;
		isa_pkg::reg_idx_t  rd;
		isa_pkg::funct3_t   funct3;
		logic               funct7_5;
		isa_pkg::word_t     imm;       // sign-extended per format
		logic               reg_wen;
		isa_pkg::word_t     pc;
		isa_pkg::word_t     dnpc;      // predicted next pc
		isa_pkg::word_t     src1;
		isa_pkg::word_t     src2;
		isa_pkg::word_t     csr_val;
	} decoded_t;

	typedef struct packed {
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t    pc;
		isa_pkg::word_t    val;
		isa_pkg::word_t    store_data;
		isa_pkg::funct3_t  funct3;     // access size for the lsu
		logic              reg_wen;
		logic              load;
		logic              store;
		isa_pkg::word_t    next_pc;
		logic              mispredict;
		logic              btb_update;
		logic              csr_wen;
		isa_pkg::word_t    csr_wdata;
	} exu_result_t;

endpackage

`default_nettype wire

//--- src/result_buffer.sv
`default_nettype none

module result_buffer (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  pipe_pkg::exu_result_t in_result,
	output logic                  out_valid,
	input  logic                  out_ready,
	output pipe_pkg::exu_result_t out_result
);

	logic                  full;
	logic                  load;
	pipe_pkg::exu_result_t data;

	// free when empty or draining this cycle
	assign in_ready = ~full | out_ready;
	assign load     = in_valid & in_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;  // refill, possibly while unloading
		else if (out_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (load)
			data <= in_result;
	end

	assign out_valid  = full;
	assign out_result = data;

endmodule

`default_nettype wire

//--- verification/exu_assertions.sv
`default_nettype none

module exu_assertions (
	input logic                  clock,
	input logic                  rst_n,
	input logic                  in_ready,
	input logic                  res_valid,
	input logic                  res_ready,
	input pipe_pkg::exu_result_t result
);

	int fail_count = 0;  // read by the testbench at the end

	a_flags_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		!(in_ready && res_valid))
	else begin
		$error("in_ready and res_valid are high together");
		fail_count++;
	end

	// stalled result must not move
	a_result_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(result)))
	else begin
		$error("result changed or res_valid dropped while stalled");
		fail_count++;
	end

	a_ready_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> in_ready)
	else begin
		$error("in_ready low in the first cycle after reset");
		fail_count++;
	end

endmodule

bind exu exu_assertions u_assertions (
	.clock    (clock),
	.rst_n    (rst_n),
	.in_ready (in_ready),
	.res_valid(res_valid),
	.res_ready(res_ready),
	.result   (result)
);

`default_nettype wire

//--- verification/exu_tb.sv
`default_nettype none

module exu_tb;

	localparam int NUM_VEC    = 31;
	localparam int CLK_PERIOD = 20;
	localparam int VEC_W      = 372;
	localparam int WATCHDOG   = NUM_VEC * 2 * 8 * CLK_PERIOD + 50 * CLK_PERIOD;

	// one line of the data file, msb first
	typedef struct packed {
		logic [3:0]     test;
		isa_pkg::word_t inst;
		isa_pkg::word_t pc;
		isa_pkg::word_t dnpc;
		isa_pkg::word_t src1;
		isa_pkg::word_t src2;
		isa_pkg::word_t csr_val;
		logic [3:0]     redirect;
		isa_pkg::word_t csr_target;
		isa_pkg::word_t val;
		isa_pkg::word_t next_pc;
		isa_pkg::word_t store_data;
		isa_pkg::word_t csr_wdata;
		logic [1:0]     pad;
		logic           mispredict;
		logic           btb_update;
		logic           load;
		logic           store;
		logic           csr_wen;
		logic           reg_wen;
		logic [3:0]     rd;
	} vector_t;

	logic                  clock;
	logic                  rst_n;
	isa_pkg::word_t        inst, pc, dnpc, src1, src2, csr_val, csr_target;
	logic                  csr_redirect;
	logic                  in_valid;
	logic                  in_ready;
	logic                  out_valid;
	logic                  out_ready;
	pipe_pkg::exu_result_t result;

	logic [VEC_W-1:0] vec_mem [NUM_VEC];
	time              accept_times [$];
	int               out_idx = 0;
	int               errors = 0;
	int               test_errs = 0;
	int               tests_passed = 0;
	int               tests_failed = 0;
	int               seed = 32'h89e702f2;

	exu_subsystem u_dut (
		.clock(clock), .rst_n(rst_n), .inst(inst), .pc(pc), .dnpc(dnpc),
		.src1(src1), .src2(src2), .csr_val(csr_val), .csr_redirect(csr_redirect),
		.csr_target(csr_target), .in_valid(in_valid), .in_ready(in_ready),
		.out_valid(out_valid), .out_ready(out_ready), .result(result)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [3:0] test_of(input int idx);
		vector_t v;
		v = vec_mem[idx];
		return v.test;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h (vector %0d)", name, got, exp, out_idx);
			errors++;
			test_errs++;
		end
	endtask

	task automatic apply_vector(input int idx);
		vector_t v;
		v = vec_mem[idx];
		inst         = v.inst;
		pc           = v.pc;
		dnpc         = v.dnpc;
		src1         = v.src1;
		src2         = v.src2;
		csr_val      = v.csr_val;
		csr_redirect = v.redirect[0];
		csr_target   = v.csr_target;
		in_valid     = 1'b1;
	endtask

	task automatic compare_result(input int idx, input time acc);
		vector_t v;
		v = vec_mem[idx];
		check_value("val", result.val, v.val);
		check_value("next_pc", result.next_pc, v.next_pc);
		check_value("mispredict", result.mispredict, v.mispredict);
		check_value("btb_update", result.btb_update, v.btb_update);
		check_value("load", result.load, v.load);
		check_value("store", result.store, v.store);
		check_value("store_data", result.store_data, v.store_data);
		check_value("csr_wen", result.csr_wen, v.csr_wen);
		check_value("csr_wdata", result.csr_wdata, v.csr_wdata);
		check_value("rd", result.rd, v.rd);
		check_value("reg_wen", result.reg_wen, v.reg_wen);
		check_value("funct3", result.funct3, v.inst[14:12]);
		check_value("pc", result.pc, v.pc);
		if (v.test == 4'd1)  // free buffer, fixed latency
			check_value("latency_cycles", ($time - acc) / CLK_PERIOD, 2);
		if (idx == NUM_VEC - 1 || test_of(idx + 1) != v.test) begin
			$display("test %0d: %s (%0d mismatches)", v.test,
				test_errs == 0 ? "ok" : "FAILED", test_errs);
			if (test_errs == 0)
				tests_passed++;
			else
				tests_failed++;
			test_errs = 0;
		end
	endtask

	// output monitor
	always @(posedge clock) begin
		if (rst_n && out_valid && out_ready) begin
			if (out_idx >= NUM_VEC || accept_times.size() == 0) begin
				$display("a result came out that was never sent in");
				errors++;
			end else begin
				compare_result(out_idx, accept_times.pop_front());
				out_idx = out_idx + 1;
			end
		end
	end

	// back-pressure, held high through test 1
	initial begin
		forever begin
			@(posedge clock);
			#1;
			if (out_idx < NUM_VEC && test_of(out_idx) == 4'd1)
				out_ready = 1'b1;
			else
				out_ready = ($unsigned($random(seed)) % 10) < 7;
		end
	end

	initial begin
		#(WATCHDOG);
		$display("timeout: results stopped arriving");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		out_ready    = 1'b0;
		inst         = '0;
		pc           = '0;
		dnpc         = '0;
		src1         = '0;
		src2         = '0;
		csr_val      = '0;
		csr_redirect = 1'b0;
		csr_target   = '0;
		$readmemh("verification/exu_testdata.hex", vec_mem);
		repeat (2) @(posedge clock);
		#1 rst_n = 1'b1;
		@(posedge clock);
		for (int i = 0; i < NUM_VEC; i++) begin
			#1 apply_vector(i);
			do @(posedge clock); while (!in_ready);  // hold until accepted
			accept_times.push_back($time);
		end
		#1 in_valid = 1'b0;
		while (out_idx < NUM_VEC)
			@(posedge clock);
		@(posedge clock);
		$display("tests passed: %0d, tests failed: %0d, mismatches: %0d, assertion failures: %0d",
			tests_passed, tests_failed, errors, u_dut.u_exu.u_assertions.fail_count);
		if (errors == 0 && tests_failed == 0 && u_dut.u_exu.u_assertions.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/exu_testdata.hex
// test_inst_pc_dnpc_src1_src2_csrval_redirect_csrtarget then expected
// val_nextpc_storedata_csrwdata_flags(mispredict,btb,load,store,csrwen,regwen)_rd
1_003100B3_00000100_00000104_00000005_00000007_00000000_0_00000000_0000000C_00000104_00000007_00000000_01_1
1_40408133_00000104_00000108_00000005_00000009_00000000_0_00000000_FFFFFFFC_00000108_00000009_00000000_01_2
1_002091B3_00000108_0000010C_00000003_00000024_00000000_0_00000000_00000030_0000010C_00000024_00000000_01_3
1_0020A233_0000010C_00000110_FFFFFFFE_00000001_00000000_0_00000000_00000001_00000110_00000001_00000000_01_4
1_0020B2B3_00000110_00000114_FFFFFFFE_00000001_00000000_0_00000000_00000000_00000114_00000001_00000000_01_5
1_0020C333_00000114_00000118_F0F0F0F0_0FF00FF0_00000000_0_00000000_FF00FF00_00000118_0FF00FF0_00000000_01_6
1_0020D3B3_00000118_0000011C_80000000_00000004_00000000_0_00000000_08000000_0000011C_00000004_00000000_01_7
1_4020D433_0000011C_00000120_80000000_00000004_00000000_0_00000000_F8000000_00000120_00000004_00000000_01_8
1_0020E4B3_00000120_00000124_00FF0000_000000FF_00000000_0_00000000_00FF00FF_00000124_000000FF_00000000_01_9
1_0020F533_00000124_00000128_FFFF0000_0FF00FF0_00000000_0_00000000_0FF00000_00000128_0FF00FF0_00000000_01_A
1_FFF08593_00000128_0000012C_00000010_00000000_00000000_0_00000000_0000000F_0000012C_00000000_00000000_01_B
1_12345637_0000012C_00000130_00000000_00000000_00000000_0_00000000_12345000_00000130_00000000_00000000_01_C
1_00001697_00000130_00000134_00000000_00000000_00000000_0_00000000_00001130_00000134_00000000_00000000_01_D
2_00208463_00000200_00000208_00000005_00000005_00000000_0_00000000_00000208_00000208_00000005_00000000_00_8
2_00209463_00000200_00000208_00000005_00000005_00000000_0_00000000_00000208_00000204_00000005_00000000_20_8
2_0020C463_00000200_00000208_FFFFFFFF_00000001_00000000_0_00000000_00000208_00000208_00000001_00000000_00_8
2_0020D463_00000200_00000204_FFFFFFFF_00000001_00000000_0_00000000_00000208_00000204_00000001_00000000_00_8
2_0020E463_00000200_00000204_FFFFFFFF_00000001_00000000_0_00000000_00000208_00000204_00000001_00000000_00_8
2_FE20FCE3_00000200_00000204_FFFFFFFF_00000001_00000000_0_00000000_000001F8_000001F8_00000001_00000000_30_9
3_010000EF_00000300_00000304_00000000_00000000_00000000_0_00000000_00000304_00000310_00000000_00000000_31_1
3_008302E7_00000304_00001008_00001000_00000000_00000000_0_00000000_00000308_00001008_00000000_00000000_01_5
3_003100B3_00000308_0000030C_00000001_00000002_00000000_1_80000000_00000003_80000000_00000002_00000000_21_1
3_010000EF_00000300_00000310_00000000_00000000_00000000_1_00000800_00000304_00000800_00000000_00000000_31_1
4_00412383_00000400_00000404_00001000_00000000_00000000_0_00000000_00001004_00000404_00000000_00000000_09_7
4_00312423_00000404_00000408_00001000_CAFEBABE_00000000_0_00000000_00001008_00000408_CAFEBABE_00000000_04_8
5_300110F3_00000500_00000504_00000011_00000000_00000022_0_00000000_00000022_00000504_00000000_00000011_03_1
5_300120F3_00000504_00000508_00000011_00000000_00000022_0_00000000_00000022_00000508_00000000_00000033_03_1
5_00000073_00000508_0000050C_00000011_00000000_00000044_0_00000000_00000044_0000050C_00000000_00000000_00_0
6_7FF00713_00000600_00000604_00000000_00000000_00000000_0_00000000_000007FF_00000604_00000000_00000000_01_E
6_003107B3_00000604_00000608_7FFFFFFF_00000001_00000000_0_00000000_80000000_00000608_00000001_00000000_01_F
6_FFF0C093_00000608_0000060C_12345678_00000000_00000000_0_00000000_EDCBA987_0000060C_00000000_00000000_01_1
